/* source/cl_aos_pkg.sv */
// Shared definitions for the AOS memory-drive design
// Host address map, register offsets, memory widths and bus structs
`default_nettype none

package cl_aos_pkg;

	// ------------------------------------------------------------------------
	// Application slots and host window
	// ------------------------------------------------------------------------
	localparam int NUM_APPS    = 2;
	localparam int APP_SEL_W   = 1;
	localparam int AXIL_ADDR_W = 32;
	localparam int SR_DATA_W   = 32;

	// Byte address = slot index, register offset, two zero bits
	localparam int REG_OFS_LSB = 2;
	localparam int REG_OFS_W   = 4;
	localparam int APP_SEL_LSB = 6;

	// Register offsets within one slot
	localparam logic [REG_OFS_W-1:0] REG_MEM_ADDR = 4'd0;
	localparam logic [REG_OFS_W-1:0] REG_WR_DATA  = 4'd1;
	localparam logic [REG_OFS_W-1:0] REG_CMD      = 4'd2;
	localparam logic [REG_OFS_W-1:0] REG_RD_DATA  = 4'd3;
	localparam logic [REG_OFS_W-1:0] REG_STATUS   = 4'd4;

	// ------------------------------------------------------------------------
	// Memory channel
	// ------------------------------------------------------------------------
	localparam int MEM_WORD_ADDR_W = 8;
	// Slot index sits on top of the word address
	localparam int MEM_ADDR_W      = APP_SEL_W + MEM_WORD_ADDR_W;
	localparam int DRAM_LATENCY    = 2;

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// Soft-register request, one-cycle pulse
	typedef struct packed {
		logic                   valid;
		logic                   is_write;
		logic [AXIL_ADDR_W-1:0] addr;
		logic [SR_DATA_W-1:0]   data;
	} softreg_req_t;

	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
	} softreg_resp_t;

	// Single-word memory request, held until grant
	typedef struct packed {
		logic                  valid;
		logic                  is_write;
		logic [MEM_ADDR_W-1:0] addr;
		logic [SR_DATA_W-1:0]  data;
		logic [APP_SEL_W-1:0]  tag;
	} ami_req_t;

	// Read data only, tag names the slot
	typedef struct packed {
		logic                 valid;
		logic [SR_DATA_W-1:0] data;
		logic [APP_SEL_W-1:0] tag;
	} ami_resp_t;

endpackage

`default_nettype wire

/* source/axil_softreg_bridge.sv */
// AXI4-Lite to soft-register bridge
// One access at a time; writes win over reads
// Read data is captured the cycle after the request and held for the host
`default_nettype none

module axil_softreg_bridge (
	input  wire                                    clk_main_a0,
	input  wire                                    rst_main_n,
	// Write address
	input  wire                                    awvalid,
	input  wire  [cl_aos_pkg::AXIL_ADDR_W-1:0]     awaddr,
	output logic                                   awready,
	// Write data
	input  wire                                    wvalid,
	input  wire  [cl_aos_pkg::SR_DATA_W-1:0]       wdata,
	input  wire  [cl_aos_pkg::SR_DATA_W/8-1:0]     wstrb,
	output logic                                   wready,
	// Write response
	output logic                                   bvalid,
	output logic [1:0]                             bresp,
	input  wire                                    bready,
	// Read address
	input  wire                                    arvalid,
	input  wire  [cl_aos_pkg::AXIL_ADDR_W-1:0]     araddr,
	output logic                                   arready,
	// Read data
	output logic                                   rvalid,
	output logic [cl_aos_pkg::SR_DATA_W-1:0]       rdata,
	output logic [1:0]                             rresp,
	input  wire                                    rready,
	// Soft-register side
	output cl_aos_pkg::softreg_req_t               sr_req,
	input  wire cl_aos_pkg::softreg_resp_t         sr_resp
);

	import cl_aos_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRESP,
		S_RWAIT,
		S_RRESP
	} state_t;

	state_t               state_q;
	state_t               state_nxt;
	logic                 rdy_q;
	logic                 wr_hs;
	logic                 ar_hs;
	logic [SR_DATA_W-1:0] rdata_q;

	// Address and data taken together, so each ready waits on the other valid
	assign awready = rdy_q & wvalid;
	assign wready  = rdy_q & awvalid;
	// Read only when no complete write is offered
	assign arready = rdy_q & ~(awvalid & wvalid);

	assign wr_hs = rdy_q & awvalid & wvalid;
	assign ar_hs = arready & arvalid;

	// Request pulse in the handshake cycle
	// Partial-strobe writes are answered but dropped
	always_comb begin
		sr_req.valid    = (wr_hs & (&wstrb)) | ar_hs;
		sr_req.is_write = wr_hs;
		sr_req.addr     = wr_hs ? awaddr : araddr;
		sr_req.data     = wdata;
	end

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			S_IDLE: begin
				if (wr_hs) begin
					state_nxt = S_WRESP;
				end else if (ar_hs) begin
					state_nxt = S_RWAIT;
				end
			end
			S_WRESP: begin
				if (bready) begin
					state_nxt = S_IDLE;
				end
			end
			// Slot answers one cycle after the request
			S_RWAIT: begin
				if (sr_resp.valid) begin
					state_nxt = S_RRESP;
				end
			end
			default: begin
				if (rready) begin
					state_nxt = S_IDLE;
				end
			end
		endcase
	end

	// Ready flag trails reset by one cycle
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			state_q <= S_IDLE;
			rdy_q   <= 1'b0;
		end else begin
			state_q <= state_nxt;
			rdy_q   <= (state_nxt == S_IDLE);
		end
	end

	// Read data capture
	always_ff @(posedge clk_main_a0) begin
		if (state_q == S_RWAIT && sr_resp.valid) begin
			rdata_q <= sr_resp.data;
		end
	end

	assign bvalid = (state_q == S_WRESP);
	assign rvalid = (state_q == S_RRESP);
	assign rdata  = rdata_q;
	assign bresp  = AXI_RESP_OKAY;
	assign rresp  = AXI_RESP_OKAY;

	// Read response held under back-pressure
	a_r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

	// No new access while a response waits for the host
	a_no_accept: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		(bvalid || rvalid) |-> !(awready || wready || arready));

endmodule

`default_nettype wire

/* source/softreg_router.sv */
// Soft-register router
// Steers host requests to one slot by address, returns that slot's read data
`default_nettype none

module softreg_router (
	input  wire                              clk_main_a0,
	input  wire                              rst_main_n,
	input  wire  cl_aos_pkg::softreg_req_t   sr_req,
	output cl_aos_pkg::softreg_resp_t        sr_resp,
	output cl_aos_pkg::softreg_req_t         app_req [cl_aos_pkg::NUM_APPS],
	input  wire  cl_aos_pkg::softreg_resp_t  app_resp [cl_aos_pkg::NUM_APPS]
);

	import cl_aos_pkg::*;

	logic [APP_SEL_W-1:0] req_sel;
	logic [APP_SEL_W-1:0] rd_sel_q;
	logic [NUM_APPS-1:0]  resp_vld;

	// Slot index straight from the byte address
	assign req_sel = sr_req.addr[APP_SEL_LSB +: APP_SEL_W];

	// Payload fans out, valid only to the addressed slot
	always_comb begin
		for (int i = 0; i < NUM_APPS; i++) begin
			app_req[i]       = sr_req;
			app_req[i].valid = sr_req.valid && (req_sel == APP_SEL_W'(i));
			resp_vld[i]      = app_resp[i].valid;
		end
	end

	// Remember who owes the read answer
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			rd_sel_q <= '0;
		end else if (sr_req.valid && !sr_req.is_write) begin
			rd_sel_q <= req_sel;
		end
	end

	assign sr_resp = app_resp[rd_sel_q];

	// Slots answer only their own reads
	a_resp_onehot: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		$onehot0(resp_vld));

	a_resp_owner: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		(resp_vld != '0) |-> resp_vld[rd_sel_q]);

endmodule

`default_nettype wire

/* source/mem_drive_app.sv */
// Memory-drive application slot
// Register file plus a one-deep command engine
// CMD bit 0 picks a write of WR_DATA or a read into RD_DATA at MEM_ADDR
`default_nettype none

module mem_drive_app (
	input  wire                              clk_main_a0,
	input  wire                              rst_main_n,
	input  wire  cl_aos_pkg::softreg_req_t   sr_req,
	output cl_aos_pkg::softreg_resp_t        sr_resp,
	output cl_aos_pkg::ami_req_t             mem_req,
	input  wire                              mem_grant,
	input  wire  cl_aos_pkg::ami_resp_t      mem_resp
);

	import cl_aos_pkg::*;

	logic [REG_OFS_W-1:0]       ofs;
	logic                       reg_wr;
	logic                       reg_rd;
	logic [MEM_WORD_ADDR_W-1:0] mem_addr_q;
	logic [SR_DATA_W-1:0]       wr_data_q;
	logic [SR_DATA_W-1:0]       rd_data_q;
	logic                       busy_q;
	logic                       req_vld_q;
	logic                       op_wr_q;
	logic [15:0]                op_cnt_q;
	logic                       op_done;
	logic [SR_DATA_W-1:0]       rd_mux;
	logic                       resp_vld_q;
	logic [SR_DATA_W-1:0]       resp_data_q;

	assign ofs    = sr_req.addr[REG_OFS_LSB +: REG_OFS_W];
	assign reg_wr = sr_req.valid & sr_req.is_write;
	assign reg_rd = sr_req.valid & ~sr_req.is_write;

	// Writes finish at grant, reads at response
	assign op_done = (req_vld_q & mem_grant & op_wr_q) | mem_resp.valid;

	// ------------------------------------------------------------------------
	// Registers and command engine
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			mem_addr_q <= '0;
			wr_data_q  <= '0;
			rd_data_q  <= '0;
			busy_q     <= 1'b0;
			req_vld_q  <= 1'b0;
			op_wr_q    <= 1'b0;
			op_cnt_q   <= '0;
		end else begin
			if (reg_wr && ofs == REG_MEM_ADDR) begin
				mem_addr_q <= sr_req.data[MEM_WORD_ADDR_W-1:0];
			end
			if (reg_wr && ofs == REG_WR_DATA) begin
				wr_data_q <= sr_req.data;
			end
			// New command only when idle
			if (reg_wr && ofs == REG_CMD && !busy_q) begin
				busy_q    <= 1'b1;
				req_vld_q <= 1'b1;
				op_wr_q   <= sr_req.data[0];
			end
			// Request leaves on grant
			if (req_vld_q && mem_grant) begin
				req_vld_q <= 1'b0;
			end
			if (mem_resp.valid) begin
				rd_data_q <= mem_resp.data;
			end
			if (op_done) begin
				busy_q   <= 1'b0;
				op_cnt_q <= op_cnt_q + 16'd1;
			end
		end
	end

	// Zero-extended request, arbiter fills in slot bits
	always_comb begin
		mem_req.valid    = req_vld_q;
		mem_req.is_write = op_wr_q;
		mem_req.addr     = MEM_ADDR_W'(mem_addr_q);
		mem_req.data     = wr_data_q;
		mem_req.tag      = '0;
	end

	// Readback, CMD and holes read as zero
	always_comb begin
		case (ofs)
			REG_MEM_ADDR: rd_mux = SR_DATA_W'(mem_addr_q);
			REG_WR_DATA:  rd_mux = wr_data_q;
			REG_RD_DATA:  rd_mux = rd_data_q;
			REG_STATUS:   rd_mux = {op_cnt_q, 15'd0, busy_q};
			default:      rd_mux = '0;
		endcase
	end

	// Answer exactly one cycle after the read
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			resp_vld_q <= 1'b0;
		end else begin
			resp_vld_q <= reg_rd;
		end
	end

	always_ff @(posedge clk_main_a0) begin
		if (reg_rd) begin
			resp_data_q <= rd_mux;
		end
	end

	assign sr_resp.valid = resp_vld_q;
	assign sr_resp.data  = resp_data_q;

	// Memory data arrives only for our own outstanding read
	a_resp_expected: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		mem_resp.valid |-> busy_q && !op_wr_q && !req_vld_q);

endmodule

`default_nettype wire

/* source/ami_arbiter.sv */
// Round-robin merge of slot memory requests onto one channel
// Stamps the slot into tag and top address bits, steers responses by tag
`default_nettype none

module ami_arbiter (
	input  wire                                clk_main_a0,
	input  wire                                rst_main_n,
	input  wire  cl_aos_pkg::ami_req_t         app_mem_req [cl_aos_pkg::NUM_APPS],
	output logic [cl_aos_pkg::NUM_APPS-1:0]    app_mem_grant,
	output cl_aos_pkg::ami_resp_t              app_mem_resp [cl_aos_pkg::NUM_APPS],
	output cl_aos_pkg::ami_req_t               ch_req,
	input  wire  cl_aos_pkg::ami_resp_t        ch_resp
);

	import cl_aos_pkg::*;

	logic [APP_SEL_W-1:0] last_q;
	logic [APP_SEL_W-1:0] sel;
	logic                 found;
	ami_req_t             ch_nxt;

	// Search starts just past the last winner
	always_comb begin
		int idx;
		app_mem_grant = '0;
		sel           = last_q;
		found         = 1'b0;
		for (int k = 1; k <= NUM_APPS; k++) begin
			idx = (int'(last_q) + k) % NUM_APPS;
			if (!found && app_mem_req[idx].valid) begin
				app_mem_grant[idx] = 1'b1;
				sel                = APP_SEL_W'(idx);
				found              = 1'b1;
			end
		end
	end

	// Winner gets its slot number in tag and top address bits
	always_comb begin
		ch_nxt       = app_mem_req[sel];
		ch_nxt.valid = found;
		ch_nxt.addr  = {sel, app_mem_req[sel].addr[MEM_WORD_ADDR_W-1:0]};
		ch_nxt.tag   = sel;
	end

	// Channel register, valid only is cleared
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			ch_req.valid <= 1'b0;
			last_q       <= '0;
		end else begin
			ch_req <= ch_nxt;
			if (found) begin
				last_q <= sel;
			end
		end
	end

	// Responses back by tag
	always_comb begin
		for (int i = 0; i < NUM_APPS; i++) begin
			app_mem_resp[i]       = ch_resp;
			app_mem_resp[i].valid = ch_resp.valid && (ch_resp.tag == APP_SEL_W'(i));
		end
	end

	a_grant_onehot: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
		$onehot0(app_mem_grant));

endmodule

`default_nettype wire

/* source/sim_dram.sv */
// On-chip stand-in for the DDR channel
// Writes land at request; reads return after a fixed pipeline with their tag
`default_nettype none

module sim_dram (
	input  wire                          clk_main_a0,
	input  wire                          rst_main_n,
	input  wire  cl_aos_pkg::ami_req_t   mem_req,
	output cl_aos_pkg::ami_resp_t        mem_resp
);

	import cl_aos_pkg::*;

	logic [SR_DATA_W-1:0] mem [2**MEM_ADDR_W];
	ami_resp_t            pipe_q [DRAM_LATENCY];

	// Storage, no reset
	always_ff @(posedge clk_main_a0) begin
		if (mem_req.valid && mem_req.is_write) begin
			mem[mem_req.addr] <= mem_req.data;
		end
	end

	// Read pipeline, stage 0 samples the array
	always_ff @(posedge clk_main_a0) begin
		if (!rst_main_n) begin
			for (int k = 0; k < DRAM_LATENCY; k++) begin
				pipe_q[k].valid <= 1'b0;
			end
		end else begin
			pipe_q[0].valid <= mem_req.valid & ~mem_req.is_write;
			pipe_q[0].data  <= mem[mem_req.addr];
			pipe_q[0].tag   <= mem_req.tag;
			for (int k = 1; k < DRAM_LATENCY; k++) begin
				pipe_q[k] <= pipe_q[k-1];
			end
		end
	end

	assign mem_resp = pipe_q[DRAM_LATENCY-1];

endmodule

`default_nettype wire

/* source/cl_aos.sv */
// AOS top level
// Host AXI4-Lite window, slot router, two memory-drive slots,
// round-robin memory arbiter and the on-chip memory model
`default_nettype none

module cl_aos (
	input  wire                                clk_main_a0,
	input  wire                                rst_main_n,
	input  wire                                awvalid,
	input  wire  [cl_aos_pkg::AXIL_ADDR_W-1:0] awaddr,
	output logic                               awready,
	input  wire                                wvalid,
	input  wire  [cl_aos_pkg::SR_DATA_W-1:0]   wdata,
	input  wire  [cl_aos_pkg::SR_DATA_W/8-1:0] wstrb,
	output logic                               wready,
	output logic                               bvalid,
	output logic [1:0]                         bresp,
	input  wire                                bready,
	input  wire                                arvalid,
	input  wire  [cl_aos_pkg::AXIL_ADDR_W-1:0] araddr,
	output logic                               arready,
	output logic                               rvalid,
	output logic [cl_aos_pkg::SR_DATA_W-1:0]   rdata,
	output logic [1:0]                         rresp,
	input  wire                                rready
);

	import cl_aos_pkg::*;

	// Soft-register path
	softreg_req_t        sr_req;
	softreg_resp_t       sr_resp;
	softreg_req_t        app_req [NUM_APPS];
	softreg_resp_t       app_resp [NUM_APPS];
	// Memory path
	ami_req_t            app_mem_req [NUM_APPS];
	logic [NUM_APPS-1:0] app_mem_grant;
	ami_resp_t           app_mem_resp [NUM_APPS];
	ami_req_t            ch_req;
	ami_resp_t           ch_resp;

	axil_softreg_bridge bridge_inst (
		.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.sr_req(sr_req), .sr_resp(sr_resp)
	);

	softreg_router router_inst (
		.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
		.sr_req(sr_req), .sr_resp(sr_resp),
		.app_req(app_req), .app_resp(app_resp)
	);

	// One slot per application
	for (genvar i = 0; i < NUM_APPS; i++) begin : g_app
		mem_drive_app app_inst (
			.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
			.sr_req(app_req[i]), .sr_resp(app_resp[i]),
			.mem_req(app_mem_req[i]), .mem_grant(app_mem_grant[i]),
			.mem_resp(app_mem_resp[i])
		);
	end

	ami_arbiter arbiter_inst (
		.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
		.app_mem_req(app_mem_req), .app_mem_grant(app_mem_grant),
		.app_mem_resp(app_mem_resp),
		.ch_req(ch_req), .ch_resp(ch_resp)
	);

	sim_dram dram_inst (
		.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
		.mem_req(ch_req), .mem_resp(ch_resp)
	);

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
// Clock source for the AOS testbench
// Free-running main clock, 100 ns period
`default_nettype none

module tb_clock_gen (
	output logic clk_main_a0
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam time HALF_PERIOD = 50ns;

	initial begin
		clk_main_a0 = 1'b0;
		forever begin
			#HALF_PERIOD clk_main_a0 = ~clk_main_a0;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_cl_aos.sv */
// Testbench for the AOS memory-drive top level
// Random register and memory traffic over AXI4-Lite with random back-pressure,
// checked against a per-slot register and memory model
`default_nettype none

module tb_cl_aos;

	timeunit 1ns;
	timeprecision 1ps;

	import cl_aos_pkg::*;

	localparam int WAIT_LIMIT = 40;
	localparam int POLL_LIMIT = 20;

	logic                   clk_main_a0;
	logic                   rst_main_n;
	logic                   awvalid;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   awready;
	logic                   wvalid;
	logic [SR_DATA_W-1:0]   wdata;
	logic [SR_DATA_W/8-1:0] wstrb;
	logic                   wready;
	logic                   bvalid;
	logic [1:0]             bresp;
	logic                   bready;
	logic                   arvalid;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   arready;
	logic                   rvalid;
	logic [SR_DATA_W-1:0]   rdata;
	logic [1:0]             rresp;
	logic                   rready;

	// Random source, back-pressure switch and write strobe
	logic [31:0]            lfsr_q;
	logic                   bp_on;
	logic [SR_DATA_W/8-1:0] wr_strb;

	// Slot model
	logic [31:0] model_mem [NUM_APPS][2**MEM_WORD_ADDR_W];
	logic [7:0]  model_addr [NUM_APPS];
	logic [31:0] model_wdata [NUM_APPS];
	logic [31:0] model_rdata [NUM_APPS];
	logic [15:0] model_cnt [NUM_APPS];

	tb_clock_gen clock_inst (
		.clk_main_a0(clk_main_a0)
	);

	cl_aos cl_aos_inst (
		.clk_main_a0(clk_main_a0), .rst_main_n(rst_main_n),
		.awvalid(awvalid), .awaddr(awaddr), .awready(awready),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.arvalid(arvalid), .araddr(araddr), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready)
	);

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] reg_addr(input int slot, input logic [3:0] ofs);
		return (32'(slot) << APP_SEL_LSB) | (32'(ofs) << REG_OFS_LSB);
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			stop_run($sformatf("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, got, exp));
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step;
		@(posedge clk_main_a0);
		#1;
	endtask

	// ------------------------------------------------------------------------
	// AXI4-Lite driver
	// ------------------------------------------------------------------------
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
		int n;
		int hold;
		n       = 0;
		hold    = bp_on ? int'(rand_bits(2)) : 0;
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = data;
		wstrb   = wr_strb;
		// Address and data go in the same cycle
		@(negedge clk_main_a0);
		while (!(awready && wready)) begin
			n++;
			if (n > WAIT_LIMIT) begin
				stop_run("Timeout: write address and data were never accepted");
			end
			@(negedge clk_main_a0);
		end
		step;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = (hold == 0);
		// Response one cycle after the handshake
		@(negedge clk_main_a0);
		check_value("bvalid", bvalid, 1);
		check_value("bresp", bresp, AXI_RESP_OKAY);
		if (hold > 0) begin
			repeat (hold) step;
			bready = 1'b1;
			@(negedge clk_main_a0);
			check_value("bvalid under back-pressure", bvalid, 1);
		end
		step;
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
		int n;
		int hold;
		n       = 0;
		hold    = bp_on ? int'(rand_bits(2)) : 0;
		arvalid = 1'b1;
		araddr  = addr;
		@(negedge clk_main_a0);
		while (!arready) begin
			n++;
			if (n > WAIT_LIMIT) begin
				stop_run("Timeout: read address was never accepted");
			end
			@(negedge clk_main_a0);
		end
		step;
		arvalid = 1'b0;
		rready  = (hold == 0);
		// Request cycle, then capture cycle
		@(negedge clk_main_a0);
		check_value("rvalid early", rvalid, 0);
		@(negedge clk_main_a0);
		check_value("rvalid", rvalid, 1);
		check_value("rresp", rresp, AXI_RESP_OKAY);
		data = rdata;
		if (hold > 0) begin
			repeat (hold) step;
			rready = 1'b1;
			@(negedge clk_main_a0);
			check_value("rvalid under back-pressure", rvalid, 1);
			check_value("rdata under back-pressure", rdata, data);
		end
		step;
		rready = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// Slot access with model update
	// ------------------------------------------------------------------------
	task automatic check_reg(input int slot, input logic [3:0] ofs,
		input logic [31:0] exp, input string name);
		logic [31:0] val;
		axil_read(reg_addr(slot, ofs), val);
		check_value($sformatf("slot%0d %s", slot, name), val, exp);
	endtask

	task automatic load_regs(input int slot, input logic [31:0] addr,
		input logic [31:0] data);
		axil_write(reg_addr(slot, REG_MEM_ADDR), addr);
		model_addr[slot] = addr[7:0];
		axil_write(reg_addr(slot, REG_WR_DATA), data);
		model_wdata[slot] = data;
	endtask

	// Bit 0 picks write, upper bits are don't care
	task automatic issue_cmd(input int slot, input logic is_wr);
		logic [31:0] cmd;
		cmd = (rand_bits(31) << 1) | 32'(is_wr);
		axil_write(reg_addr(slot, REG_CMD), cmd);
		if (is_wr) begin
			model_mem[slot][model_addr[slot]] = model_wdata[slot];
		end else begin
			model_rdata[slot] = model_mem[slot][model_addr[slot]];
		end
		model_cnt[slot]++;
	endtask

	// Poll busy, then compare the completed-op count
	task automatic wait_idle(input int slot);
		logic [31:0] status;
		int          n;
		n = 0;
		axil_read(reg_addr(slot, REG_STATUS), status);
		while (status[0]) begin
			n++;
			if (n > POLL_LIMIT) begin
				stop_run($sformatf("Timeout: slot %0d stayed busy", slot));
			end
			axil_read(reg_addr(slot, REG_STATUS), status);
		end
		check_value($sformatf("slot%0d STATUS count", slot), status[31:16], model_cnt[slot]);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		int          s;
		int          first;
		logic [31:0] wa;
		logic [31:0] d;
		lfsr_q     = 32'hc138_097b;
		bp_on      = 1'b1;
		wr_strb    = 4'hf;
		rst_main_n = 1'b0;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		wstrb      = '0;
		bready     = 1'b0;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b0;
		for (int k = 0; k < NUM_APPS; k++) begin
			model_addr[k]  = '0;
			model_wdata[k] = '0;
			model_rdata[k] = '0;
			model_cnt[k]   = '0;
		end
		repeat (4) @(posedge clk_main_a0);
		// Handshake and response outputs low in reset
		@(negedge clk_main_a0);
		check_value("awready in reset", awready, 0);
		check_value("wready in reset", wready, 0);
		check_value("arready in reset", arready, 0);
		check_value("bvalid in reset", bvalid, 0);
		check_value("rvalid in reset", rvalid, 0);
		@(posedge clk_main_a0);
		#1;
		rst_main_n = 1'b1;
		// Read ready comes up once reset is gone
		step;
		@(negedge clk_main_a0);
		check_value("arready after reset", arready, 1);
		step;

		// Register readback, MEM_ADDR keeps 8 bits
		repeat (8) begin
			s = int'(rand_bits(1));
			load_regs(s, rand_bits(32), rand_bits(32));
			check_reg(s, REG_MEM_ADDR, 32'(model_addr[s]), "MEM_ADDR");
			check_reg(s, REG_WR_DATA, model_wdata[s], "WR_DATA");
		end

		// Memory write then read at random words
		repeat (12) begin
			s = int'(rand_bits(1));
			load_regs(s, rand_bits(8), rand_bits(32));
			issue_cmd(s, 1'b1);
			wait_idle(s);
			issue_cmd(s, 1'b0);
			wait_idle(s);
			check_reg(s, REG_RD_DATA, model_rdata[s], "RD_DATA");
		end

		// Same word in both slots, commands back to back
		wa    = rand_bits(8);
		d     = rand_bits(32);
		first = int'(rand_bits(1));
		load_regs(0, wa, d);
		load_regs(1, wa, ~d);
		issue_cmd(first, 1'b1);
		issue_cmd(1 - first, 1'b1);
		wait_idle(0);
		wait_idle(1);
		issue_cmd(first, 1'b0);
		issue_cmd(1 - first, 1'b0);
		wait_idle(0);
		wait_idle(1);
		check_reg(0, REG_RD_DATA, model_rdata[0], "RD_DATA");
		check_reg(1, REG_RD_DATA, model_rdata[1], "RD_DATA");

		// Write CMD lands while the read is still in flight
		bp_on = 1'b0;
		s     = int'(rand_bits(1));
		issue_cmd(s, 1'b0);
		axil_write(reg_addr(s, REG_CMD), 32'h1);
		wait_idle(s);
		check_reg(s, REG_RD_DATA, model_rdata[s], "RD_DATA");
		bp_on = 1'b1;

		// CMD, holes, read-only registers and partial strobes
		for (int k = 0; k < NUM_APPS; k++) begin
			check_reg(k, REG_CMD, 32'h0, "CMD");
			for (int o = 5; o < 16; o++) begin
				check_reg(k, 4'(o), 32'h0, $sformatf("offset %0d", o));
			end
			axil_write(reg_addr(k, REG_RD_DATA), rand_bits(32));
			axil_write(reg_addr(k, REG_STATUS), rand_bits(32));
			check_reg(k, REG_RD_DATA, model_rdata[k], "RD_DATA");
			check_reg(k, REG_STATUS, {model_cnt[k], 16'd0}, "STATUS");
			// Partial strobe is answered but dropped
			wr_strb = 4'(rand_bits(3));
			axil_write(reg_addr(k, REG_WR_DATA), ~model_wdata[k]);
			wr_strb = 4'hf;
			check_reg(k, REG_WR_DATA, model_wdata[k], "WR_DATA");
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* cl_aos.f */
source/cl_aos_pkg.sv
source/axil_softreg_bridge.sv
source/softreg_router.sv
source/mem_drive_app.sv
source/ami_arbiter.sv
source/sim_dram.sv
source/cl_aos.sv
verification/tb_clock_gen.sv
verification/tb_cl_aos.sv
